// File: list.f
+incdir+design
design/cpu_pkg.sv
design/regfile.sv
design/commit_stage.sv
design/redirect_ctrl.sv
design/mem_axi_bridge.sv
design/core_backend.sv
tests/core_backend_assert.sv
tests/tb_core_backend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the core_backend testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_core_backend \
    -f list.f -o sim_core_backend &&
./obj_dir/sim_core_backend | tee /dev/stderr | grep -q "^sim passed$" &&
echo "run_sim: PASS" && exit 0 ||
{ echo "run_sim: FAIL"; exit 1; }

// File: tests/tb_core_backend.sv
`default_nettype none

`include "cpu_defines.svh"

module tb_core_backend;

    timeunit 1ns;
    timeprecision 1ns;

    import cpu_pkg::*;

    localparam int MAX_WAIT = 200;

    logic      clk;
    logic      rst_i;
    wb_reg_t   wb        [`CPU_LANES];
    reg_addr_t rd_addr   [`CPU_READ_PORTS];
    word_t     rd_data   [`CPU_READ_PORTS];
    branch_t   branch    [`CPU_LANES];
    logic      ex_stall;
    excp_t     excp;
    word_t     next_pc;
    logic      flush;
    trace_t    trace     [`CPU_LANES];
    mem_req_t  mem_req   [`CPU_LANES];
    mem_rsp_t  mem_rsp   [`CPU_LANES];
    word_t     awaddr, wdata, araddr, rdata;
    strb_t     wstrb;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;

    // Slave memory, test copy and register file model
    word_t     slave_mem [256];
    word_t     mem_copy  [256];
    word_t     rf_model  [`CPU_REG_NUM];
    word_t     last_awaddr;
    strb_t     last_wstrb;
    word_t     last_araddr;

    core_backend u_core_backend (
        .clk(clk), .rst_i(rst_i), .wb_i(wb), .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .branch_i(branch), .ex_stall_i(ex_stall), .excp_i(excp), .next_pc_o(next_pc),
        .flush_o(flush), .trace_o(trace), .mem_req_i(mem_req), .mem_rsp_o(mem_rsp),
        .awaddr_o(awaddr), .awvalid_o(awvalid), .awready_i(awready),
        .wdata_o(wdata), .wstrb_o(wstrb), .wvalid_o(wvalid), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready),
        .araddr_o(araddr), .arvalid_o(arvalid), .arready_i(arready),
        .rdata_i(rdata), .rvalid_i(rvalid), .rready_o(rready)
    );

    always #50 clk = ~clk;

    function automatic word_t fill_word(input int idx);
        logic [7:0] b;
        b = idx[7:0];
        return {~b, b, b ^ 8'h3c, b + 8'h5a};
    endfunction

    task automatic drive_step();
        @(posedge clk);
        #10;
    endtask

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "testbench stopped on first error");
    endtask

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            stop_on_error($sformatf("FAILED at %0t ns: %s", $time, msg));
        end
    endtask

    // Failures of the bound protocol checker
    always @(negedge clk) begin
        if (u_core_backend.u_core_backend_assert.fail_cnt != 0) begin
            stop_on_error("protocol assertion failed in the bound checker");
        end
    end

    // AXI4-Lite slave samples handshakes mid cycle and answers after the edge
    initial begin
        logic aw_fire, w_fire, ar_fire, r_fire, b_fire, aw_seen, w_seen, ar_seen;
        logic got_aw, got_w, r_pend, b_pend;
        int aw_cnt, w_cnt, ar_cnt, r_cnt, b_cnt;
        word_t aw_a, w_d, ar_a;
        strb_t w_s;
        awready = 0;
        wready  = 0;
        arready = 0;
        rvalid  = 0;
        bvalid  = 0;
        rdata   = '0;
        got_aw  = 0;
        got_w   = 0;
        r_pend  = 0;
        b_pend  = 0;
        aw_cnt  = 0;
        w_cnt   = 0;
        ar_cnt  = 0;
        r_cnt   = 0;
        b_cnt   = 0;
        for (int i = 0; i < 256; i++) begin
            slave_mem[i] = fill_word(i);
        end
        forever begin
            @(negedge clk);
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            ar_fire = arvalid && arready;
            r_fire  = rvalid && rready;
            b_fire  = bvalid && bready;
            aw_seen = awvalid;
            w_seen  = wvalid;
            ar_seen = arvalid;
            if (aw_fire) aw_a = awaddr;
            if (w_fire) begin
                w_d = wdata;
                w_s = wstrb;
            end
            if (ar_fire) begin
                ar_a        = araddr;
                last_araddr = araddr;
            end
            drive_step();
            if (aw_fire) begin
                awready = 0;
                aw_cnt  = $urandom % 4;
                got_aw  = 1;
            end else if (aw_seen && !awready) begin
                if (aw_cnt == 0) awready = 1;
                else aw_cnt--;
            end
            if (w_fire) begin
                wready = 0;
                w_cnt  = $urandom % 4;
                got_w  = 1;
            end else if (w_seen && !wready) begin
                if (w_cnt == 0) wready = 1;
                else w_cnt--;
            end
            if (ar_fire) begin
                arready = 0;
                ar_cnt  = $urandom % 4;
                r_pend  = 1;
                r_cnt   = $urandom % 4;
            end else if (ar_seen && !arready) begin
                if (ar_cnt == 0) arready = 1;
                else ar_cnt--;
            end
            if (r_fire) rvalid = 0;
            if (r_pend) begin
                if (r_cnt == 0) begin
                    rvalid = 1;
                    rdata  = slave_mem[ar_a[9:2]];
                    r_pend = 0;
                end else r_cnt--;
            end
            // Write lands in memory once both channels are in
            if (got_aw && got_w) begin
                for (int b = 0; b < `CPU_STRB_W; b++) begin
                    if (w_s[b]) slave_mem[aw_a[9:2]][8*b +: 8] = w_d[8*b +: 8];
                end
                last_awaddr = aw_a;
                last_wstrb  = w_s;
                got_aw = 0;
                got_w  = 0;
                b_pend = 1;
                b_cnt  = $urandom % 4;
            end
            if (b_fire) bvalid = 0;
            if (b_pend) begin
                if (b_cnt == 0) begin
                    bvalid = 1;
                    b_pend = 0;
                end else b_cnt--;
            end
        end
    end

    task automatic reset_test();
        @(negedge clk);
        check(!awvalid && !wvalid && !bready && !arvalid && !rready,
              "AXI valid or ready high after reset");
        for (int l = 0; l < `CPU_LANES; l++) begin
            check(!mem_rsp[l].done, "done high after reset");
            check(trace[l].wen == 4'b0000, "trace wen set after reset");
        end
        for (int r = 0; r < `CPU_REG_NUM; r += `CPU_READ_PORTS) begin
            drive_step();
            for (int p = 0; p < `CPU_READ_PORTS; p++) rd_addr[p] = reg_addr_t'(r + p);
            @(negedge clk);
            for (int p = 0; p < `CPU_READ_PORTS; p++) begin
                check(rd_data[p] == '0, $sformatf("register %0d not zero after reset", r + p));
            end
        end
    endtask

    // Commit on both lanes and check reads and trace one cycle later
    task automatic commit_pair(input int a0, input word_t d0, input logic we0,
                               input int a1, input word_t d1, input logic we1);
        reg_addr_t addr [`CPU_LANES];
        word_t     data [`CPU_LANES];
        logic      we   [`CPU_LANES];
        addr[0] = reg_addr_t'(a0);
        addr[1] = reg_addr_t'(a1);
        data[0] = d0;
        data[1] = d1;
        we[0] = we0;
        we[1] = we1;
        drive_step();
        for (int l = 0; l < `CPU_LANES; l++) begin
            wb[l].we    = we[l];
            wb[l].pc    = 32'h1c00_0000 + 32'(a0 * 16 + l * 4);
            wb[l].waddr = addr[l];
            wb[l].wdata = data[l];
            if (we[l] && addr[l] != '0) rf_model[addr[l]] = data[l];
        end
        drive_step();
        wb[0].we = 0;
        wb[1].we = 0;
        rd_addr[0] = addr[0];
        rd_addr[1] = addr[1];
        rd_addr[2] = '0;
        rd_addr[3] = addr[0] + 5'd1;
        @(negedge clk);
        for (int p = 0; p < `CPU_READ_PORTS; p++) begin
            check(rd_data[p] == rf_model[rd_addr[p]],
                  $sformatf("read port %0d reg %0d got %h", p, rd_addr[p], rd_data[p]));
        end
        for (int l = 0; l < `CPU_LANES; l++) begin
            check(trace[l].pc == 32'h1c00_0000 + 32'(a0 * 16 + l * 4), "trace pc mismatch");
            check(trace[l].wnum == addr[l] && trace[l].wdata == data[l],
                  $sformatf("trace lane %0d register or data mismatch", l));
            check(trace[l].wen == {3'b000, we[l] && addr[l] != '0},
                  $sformatf("trace lane %0d wen %b", l, trace[l].wen));
        end
    endtask

    task automatic redirect_test();
        logic  t0, t1;
        word_t exp_pc;
        logic  exp_flush;
        branch[0].target = 32'h0000_1100;
        branch[1].target = 32'h0000_2200;
        excp.eentry      = 32'h0000_3300;
        excp.tlbrentry   = 32'h0000_4400;
        excp.era         = 32'h0000_5500;
        for (int c = 0; c < 64; c++) begin
            drive_step();
            branch[0].taken = c[0];
            branch[1].taken = c[1];
            ex_stall        = c[2];
            excp.excp_flush = c[3];
            excp.tlbrefill  = c[4];
            excp.ertn_flush = c[5];
            t0 = c[0] && !c[2];
            t1 = c[1] && !c[2];
            if (t0) exp_pc = 32'h0000_1100;
            else if (t1) exp_pc = 32'h0000_2200;
            else if (c[3] && c[4]) exp_pc = 32'h0000_4400;
            else if (c[3]) exp_pc = 32'h0000_3300;
            else if (c[5]) exp_pc = 32'h0000_5500;
            else exp_pc = '0;
            exp_flush = t0 || t1 || c[3] || c[5];
            @(negedge clk);
            check(next_pc == exp_pc && flush == exp_flush,
                  $sformatf("case %0d next_pc %h flush %b", c, next_pc, flush));
        end
        drive_step();
        branch[0].taken = 0;
        branch[1].taken = 0;
        excp.excp_flush = 0;
        excp.ertn_flush = 0;
    endtask

    // Lane 0 writes and lane 1 reads, issued in the same cycle
    task automatic mem_pair(input int widx, input word_t wd, input strb_t sel, input int ridx);
        logic got0, got1;
        int   cycles;
        got0 = 0;
        got1 = 0;
        cycles = 0;
        for (int b = 0; b < `CPU_STRB_W; b++) begin
            if (sel[b]) mem_copy[widx][8*b +: 8] = wd[8*b +: 8];
        end
        drive_step();
        mem_req[0] = '{valid: 1'b1, we: 1'b1, addr: 32'(widx * 4), wdata: wd, sel: sel};
        mem_req[1] = '{valid: 1'b1, we: 1'b0, addr: 32'(ridx * 4), wdata: '0, sel: '0};
        while (!(got0 && got1)) begin
            @(negedge clk);
            if (mem_rsp[1].done) begin
                check(got0, "lane 1 finished before lane 0");
                check(last_araddr == 32'(ridx * 4),
                      $sformatf("slave saw read address %h", last_araddr));
                check(mem_rsp[1].rdata == mem_copy[ridx],
                      $sformatf("read of word %0d got %h expected %h",
                                ridx, mem_rsp[1].rdata, mem_copy[ridx]));
                got1 = 1;
            end
            if (mem_rsp[0].done) begin
                check(last_awaddr == 32'(widx * 4) && last_wstrb == sel,
                      $sformatf("slave saw address %h strobe %b", last_awaddr, last_wstrb));
                got0 = 1;
            end
            cycles++;
            if (cycles > MAX_WAIT) stop_on_error("timeout waiting for memory lane done");
            drive_step();
            if (got0) mem_req[0].valid = 0;
            if (got1) mem_req[1].valid = 0;
        end
    endtask

    task automatic mem_random();
        int    widx, ridx;
        word_t wd;
        strb_t sel;
        for (int n = 0; n < 24; n++) begin
            widx = $urandom % 256;
            ridx = ($urandom % 2 == 0) ? widx : int'($urandom % 256);
            wd   = $urandom;
            sel  = strb_t'($urandom % 15 + 1);
            mem_pair(widx, wd, sel, ridx);
        end
    endtask

    initial begin
        void'($urandom(32'h9cad5861));
        clk = 0;
        rst_i = 1;
        ex_stall = 0;
        excp = '0;
        for (int l = 0; l < `CPU_LANES; l++) begin
            wb[l] = '0;
            branch[l] = '0;
            mem_req[l] = '0;
        end
        for (int p = 0; p < `CPU_READ_PORTS; p++) rd_addr[p] = '0;
        for (int i = 0; i < 256; i++) mem_copy[i] = fill_word(i);
        for (int r = 0; r < `CPU_REG_NUM; r++) rf_model[r] = '0;
        repeat (2) @(posedge clk);
        #10;
        rst_i = 0;
        reset_test();
        commit_pair(5, 32'h1111_0005, 1, 9, 32'h2222_0009, 1);
        commit_pair(0, 32'hdead_beef, 1, 7, 32'h3333_0007, 1);
        commit_pair(12, 32'h4444_000c, 1, 12, 32'h5555_000c, 1);
        commit_pair(3, 32'h6666_0003, 0, 0, 32'h7777_0000, 1);
        redirect_test();
        mem_pair(17, 32'haabb_ccdd, 4'b0101, 17);
        mem_random();
        if (u_core_backend.u_core_backend_assert.fail_cnt == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            stop_on_error("protocol assertion failed in the bound checker");
        end
    end

endmodule

`default_nettype wire

// File: tests/core_backend_assert.sv
`default_nettype none

module core_backend_assert (
    input  logic            clk,
    input  logic            rst_i,
    input  cpu_pkg::word_t  awaddr_i,
    input  logic            awvalid_i,
    input  logic            awready_i,
    input  cpu_pkg::word_t  wdata_i,
    input  cpu_pkg::strb_t  wstrb_i,
    input  logic            wvalid_i,
    input  logic            wready_i,
    input  cpu_pkg::word_t  araddr_i,
    input  logic            arvalid_i,
    input  logic            arready_i,
    input  logic [1:0]      done_i,
    input  cpu_pkg::trace_t trace0_i,
    input  cpu_pkg::trace_t trace1_i
);

    timeunit 1ns;
    timeprecision 1ns;

    import cpu_pkg::*;

    // Number of failed assertions
    int unsigned fail_cnt = 0;

    // Valid held with stable payload until ready
    a_aw_hold: assert property (@(posedge clk) disable iff (rst_i)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            fail_cnt++;
            $error("AW valid dropped or address changed before ready");
        end
    a_w_hold: assert property (@(posedge clk) disable iff (rst_i)
        wvalid_i && !wready_i |=> wvalid_i && $stable(wdata_i) && $stable(wstrb_i))
        else begin
            fail_cnt++;
            $error("W valid dropped or payload changed before ready");
        end
    a_ar_hold: assert property (@(posedge clk) disable iff (rst_i)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin
            fail_cnt++;
            $error("AR valid dropped or address changed before ready");
        end

    // Done is a single cycle pulse per lane
    a_done0_pulse: assert property (@(posedge clk) disable iff (rst_i)
        done_i[0] |=> !done_i[0])
        else begin
            fail_cnt++;
            $error("Lane 0 done high for two cycles");
        end
    a_done1_pulse: assert property (@(posedge clk) disable iff (rst_i)
        done_i[1] |=> !done_i[1])
        else begin
            fail_cnt++;
            $error("Lane 1 done high for two cycles");
        end

    a_trace0_zero: assert property (@(posedge clk) disable iff (rst_i)
        trace0_i.wnum == '0 |-> trace0_i.wen == 4'b0000)
        else begin
            fail_cnt++;
            $error("Trace lane 0 enabled for register 0");
        end
    a_trace1_zero: assert property (@(posedge clk) disable iff (rst_i)
        trace1_i.wnum == '0 |-> trace1_i.wen == 4'b0000)
        else begin
            fail_cnt++;
            $error("Trace lane 1 enabled for register 0");
        end

endmodule

bind core_backend core_backend_assert u_core_backend_assert (
    .clk       (clk),
    .rst_i     (rst_i),
    .awaddr_i  (awaddr_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .wdata_i   (wdata_o),
    .wstrb_i   (wstrb_o),
    .wvalid_i  (wvalid_o),
    .wready_i  (wready_i),
    .araddr_i  (araddr_o),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .done_i    ({mem_rsp_o[1].done, mem_rsp_o[0].done}),
    .trace0_i  (trace_o[0]),
    .trace1_i  (trace_o[1])
);

`default_nettype wire

// File: design/core_backend.sv
`default_nettype none

`include "cpu_defines.svh"

module core_backend (
    input  logic               clk,
    input  logic               rst_i,

    // Writeback lanes
    input  cpu_pkg::wb_reg_t   wb_i      [`CPU_LANES],

    // Register read ports
    input  cpu_pkg::reg_addr_t rd_addr_i [`CPU_READ_PORTS],
    output cpu_pkg::word_t     rd_data_o [`CPU_READ_PORTS],

    // Redirect
    input  cpu_pkg::branch_t   branch_i  [`CPU_LANES],
    input  logic               ex_stall_i,
    input  cpu_pkg::excp_t     excp_i,
    output cpu_pkg::word_t     next_pc_o,
    output logic               flush_o,

    // Debug trace
    output cpu_pkg::trace_t    trace_o   [`CPU_LANES],

    // Memory stage lanes
    input  cpu_pkg::mem_req_t  mem_req_i [`CPU_LANES],
    output cpu_pkg::mem_rsp_t  mem_rsp_o [`CPU_LANES],

    // AXI4-Lite master
    output cpu_pkg::word_t     awaddr_o,
    output logic               awvalid_o,
    input  logic               awready_i,
    output cpu_pkg::word_t     wdata_o,
    output cpu_pkg::strb_t     wstrb_o,
    output logic               wvalid_o,
    input  logic               wready_i,
    input  logic               bvalid_i,
    output logic               bready_o,
    output cpu_pkg::word_t     araddr_o,
    output logic               arvalid_o,
    input  logic               arready_i,
    input  cpu_pkg::word_t     rdata_i,
    input  logic               rvalid_i,
    output logic               rready_o
);

    import cpu_pkg::*;

    // Commit stage to register file
    logic      rf_we    [`CPU_LANES];
    reg_addr_t rf_waddr [`CPU_LANES];
    word_t     rf_wdata [`CPU_LANES];

    commit_stage u_commit_stage (
        .clk        (clk),
        .rst_i      (rst_i),
        .wb_i       (wb_i),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .trace_o    (trace_o)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst_i   (rst_i),
        .we_i    (rf_we),
        .waddr_i (rf_waddr),
        .wdata_i (rf_wdata),
        .raddr_i (rd_addr_i),
        .rdata_o (rd_data_o)
    );

    redirect_ctrl u_redirect_ctrl (
        .branch_i   (branch_i),
        .ex_stall_i (ex_stall_i),
        .excp_i     (excp_i),
        .next_pc_o  (next_pc_o),
        .flush_o    (flush_o)
    );

    mem_axi_bridge u_mem_axi_bridge (
        .clk       (clk),
        .rst_i     (rst_i),
        .mem_req_i (mem_req_i),
        .mem_rsp_o (mem_rsp_o),
        .awaddr_o  (awaddr_o),
        .awvalid_o (awvalid_o),
        .awready_i (awready_i),
        .wdata_o   (wdata_o),
        .wstrb_o   (wstrb_o),
        .wvalid_o  (wvalid_o),
        .wready_i  (wready_i),
        .bvalid_i  (bvalid_i),
        .bready_o  (bready_o),
        .araddr_o  (araddr_o),
        .arvalid_o (arvalid_o),
        .arready_i (arready_i),
        .rdata_i   (rdata_i),
        .rvalid_i  (rvalid_i),
        .rready_o  (rready_o)
    );

endmodule

`default_nettype wire

// File: design/mem_axi_bridge.sv
`default_nettype none

`include "cpu_defines.svh"

module mem_axi_bridge (
    input  logic              clk,
    input  logic              rst_i,

    // Memory stage lanes
    input  cpu_pkg::mem_req_t mem_req_i [`CPU_LANES],
    output cpu_pkg::mem_rsp_t mem_rsp_o [`CPU_LANES],

    // AXI4-Lite write address
    output cpu_pkg::word_t    awaddr_o,
    output logic              awvalid_o,
    input  logic              awready_i,

    // AXI4-Lite write data
    output cpu_pkg::word_t    wdata_o,
    output cpu_pkg::strb_t    wstrb_o,
    output logic              wvalid_o,
    input  logic              wready_i,

    // AXI4-Lite write response
    input  logic              bvalid_i,
    output logic              bready_o,

    // AXI4-Lite read address and data
    output cpu_pkg::word_t    araddr_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    input  cpu_pkg::word_t    rdata_i,
    input  logic              rvalid_i,
    output logic              rready_o
);

    import cpu_pkg::*;

    localparam int LANE_W = $clog2(`CPU_LANES);

    bridge_state_e         state_q;
    bridge_state_e         state_d;
    logic [LANE_W-1:0]     lane_q;
    logic [LANE_W-1:0]     pick_lane;
    logic                  pick_valid;
    logic                  aw_done_q;
    logic                  w_done_q;
    logic                  aw_fin;
    logic                  w_fin;
    logic [`CPU_LANES-1:0] done_q;
    word_t                 addr_q;
    word_t                 wdata_q;
    strb_t                 strb_q;
    word_t                 rdata_q [`CPU_LANES];

    // Lane 0 first. A lane that is just finishing is not picked again
    always_comb begin
        pick_valid = 1'b0;
        pick_lane  = '0;
        for (int k = `CPU_LANES - 1; k >= 0; k--) begin
            if (mem_req_i[k].valid && !done_q[k]) begin
                pick_valid = 1'b1;
                pick_lane  = LANE_W'(k);
            end
        end
    end

    assign arvalid_o = (state_q == READ_ADDR);
    assign rready_o  = (state_q == READ_DATA);
    assign awvalid_o = (state_q == WRITE_REQ) && !aw_done_q;
    assign wvalid_o  = (state_q == WRITE_REQ) && !w_done_q;
    assign bready_o  = (state_q == WRITE_RESP);

    assign awaddr_o = addr_q;
    assign araddr_o = addr_q;
    assign wdata_o  = wdata_q;
    assign wstrb_o  = strb_q;

    // Address and data channels retire on their own
    assign aw_fin = aw_done_q || (awvalid_o && awready_i);
    assign w_fin  = w_done_q || (wvalid_o && wready_i);

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (pick_valid) begin
                    state_d = mem_req_i[pick_lane].we ? WRITE_REQ : READ_ADDR;
                end
            end
            READ_ADDR:  if (arready_i) state_d = READ_DATA;
            READ_DATA:  if (rvalid_i) state_d = IDLE;
            WRITE_REQ:  if (aw_fin && w_fin) state_d = WRITE_RESP;
            WRITE_RESP: if (bvalid_i) state_d = IDLE;
            default:    state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= IDLE;
            lane_q    <= '0;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            done_q    <= '0;
        end else begin
            state_q <= state_d;
            done_q  <= '0;
            if (state_q == IDLE) begin
                aw_done_q <= 1'b0;
                w_done_q  <= 1'b0;
                if (pick_valid) begin
                    lane_q <= pick_lane;
                end
            end else if (state_q == WRITE_REQ) begin
                aw_done_q <= aw_fin;
                w_done_q  <= w_fin;
            end
            // One cycle done pulse to the served lane
            if ((rready_o && rvalid_i) || (bready_o && bvalid_i)) begin
                done_q[lane_q] <= 1'b1;
            end
        end
    end

    // Request captured once, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state_q == IDLE && pick_valid) begin
            addr_q  <= mem_req_i[pick_lane].addr;
            wdata_q <= mem_req_i[pick_lane].wdata;
            strb_q  <= mem_req_i[pick_lane].sel;
        end
        if (rready_o && rvalid_i) begin
            rdata_q[lane_q] <= rdata_i;
        end
    end

    always_comb begin
        for (int k = 0; k < `CPU_LANES; k++) begin
            mem_rsp_o[k].done  = done_q[k];
            mem_rsp_o[k].rdata = rdata_q[k];
        end
    end

endmodule

`default_nettype wire

// File: design/redirect_ctrl.sv
`default_nettype none

`include "cpu_defines.svh"

module redirect_ctrl (
    input  cpu_pkg::branch_t branch_i [`CPU_LANES],
    input  logic             ex_stall_i,
    input  cpu_pkg::excp_t   excp_i,
    output cpu_pkg::word_t   next_pc_o,
    output logic             flush_o
);

    import cpu_pkg::*;

    logic [`CPU_LANES-1:0] taken;
    word_t                 trap_pc;

    // A stalled execute stage may still hold a stale branch outcome
    always_comb begin
        for (int l = 0; l < `CPU_LANES; l++) begin
            taken[l] = branch_i[l].taken && !ex_stall_i;
        end
    end

    // TLB refill has its own entry point
    assign trap_pc = excp_i.tlbrefill ? excp_i.tlbrentry : excp_i.eentry;

    always_comb begin
        if (taken[0]) begin
            next_pc_o = branch_i[0].target;
        end else if (taken[1]) begin
            next_pc_o = branch_i[1].target;
        end else if (excp_i.excp_flush) begin
            next_pc_o = trap_pc;
        end else if (excp_i.ertn_flush) begin
            next_pc_o = excp_i.era;
        end else begin
            next_pc_o = '0;
        end
    end

    assign flush_o = (|taken) || excp_i.excp_flush || excp_i.ertn_flush;

endmodule

`default_nettype wire

// File: design/commit_stage.sv
`default_nettype none

`include "cpu_defines.svh"

module commit_stage (
    input  logic               clk,
    input  logic               rst_i,

    // Writeback lanes from the pipeline
    input  cpu_pkg::wb_reg_t   wb_i       [`CPU_LANES],

    // To the register file
    output logic               rf_we_o    [`CPU_LANES],
    output cpu_pkg::reg_addr_t rf_waddr_o [`CPU_LANES],
    output cpu_pkg::word_t     rf_wdata_o [`CPU_LANES],

    // Debug trace, one cycle behind writeback
    output cpu_pkg::trace_t    trace_o    [`CPU_LANES]
);

    import cpu_pkg::*;

    localparam reg_addr_t ZERO_REG = '0;

    // Drop writes to register 0
    always_comb begin
        for (int l = 0; l < `CPU_LANES; l++) begin
            rf_we_o[l]    = wb_i[l].we && (wb_i[l].waddr != ZERO_REG);
            rf_waddr_o[l] = wb_i[l].waddr;
            rf_wdata_o[l] = wb_i[l].wdata;
        end
    end

    // Trace record, only wen is cleared at reset
    always_ff @(posedge clk) begin
        for (int l = 0; l < `CPU_LANES; l++) begin
            trace_o[l].pc    <= wb_i[l].pc;
            trace_o[l].wnum  <= wb_i[l].waddr;
            trace_o[l].wdata <= wb_i[l].wdata;
            if (rst_i) begin
                trace_o[l].wen <= 4'b0000;
            end else begin
                trace_o[l].wen <= {3'b000, rf_we_o[l]};
            end
        end
    end

endmodule

`default_nettype wire

// File: design/regfile.sv
`default_nettype none

`include "cpu_defines.svh"

module regfile (
    input  logic                       clk,
    input  logic                       rst_i,

    // Write ports, one per commit lane
    input  logic                       we_i    [`CPU_LANES],
    input  logic [`CPU_REG_ADDR_W-1:0] waddr_i [`CPU_LANES],
    input  logic [`CPU_XLEN-1:0]       wdata_i [`CPU_LANES],

    // Combinational read ports
    input  logic [`CPU_REG_ADDR_W-1:0] raddr_i [`CPU_READ_PORTS],
    output logic [`CPU_XLEN-1:0]       rdata_o [`CPU_READ_PORTS]
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_NUM];

    // Lanes applied in order, so the higher lane wins on a collision.
    // Register 0 is never written, the commit stage masks it.
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < `CPU_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int l = 0; l < `CPU_LANES; l++) begin
                if (we_i[l]) begin
                    regs[waddr_i[l]] <= wdata_i[l];
                end
            end
        end
    end

    // No bypass from the write ports
    always_comb begin
        for (int p = 0; p < `CPU_READ_PORTS; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
        end
    end

endmodule

`default_nettype wire

// File: design/cpu_pkg.sv
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

    typedef logic [`CPU_XLEN-1:0] word_t;
    typedef logic [`CPU_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`CPU_STRB_W-1:0] strb_t;

    // One writeback lane from the pipeline
    typedef struct packed {
        logic      we;
        word_t     pc;
        reg_addr_t waddr;
        word_t     wdata;
    } wb_reg_t;

    // Debug trace record, wen is byte style with only bit 0 in use
    typedef struct packed {
        word_t      pc;
        logic [3:0] wen;
        reg_addr_t  wnum;
        word_t      wdata;
    } trace_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } branch_t;

    // Trap redirect information from the CSR side
    typedef struct packed {
        logic  excp_flush;
        logic  tlbrefill;
        logic  ertn_flush;
        word_t eentry;
        word_t tlbrentry;
        word_t era;
    } excp_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        word_t addr;
        word_t wdata;
        strb_t sel;
    } mem_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } mem_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_ADDR,
        READ_DATA,
        WRITE_REQ,
        WRITE_RESP
    } bridge_state_e;

endpackage

`default_nettype wire

// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Data and address width
`define CPU_XLEN 32

// General register file geometry
`define CPU_REG_NUM 32
`define CPU_REG_ADDR_W 5
`define CPU_READ_PORTS 4

// Commit lanes and memory lanes
`define CPU_LANES 2

// Byte strobe per data word
`define CPU_STRB_W 4

`endif
